/* mem_pkg.sv */
`default_nettype none

package mem_pkg;

   localparam int MEM_ADDR_W = 8;            // 256 byte address space
   localparam int LANES      = 4;            // Byte lanes per row
   localparam int ROW_W      = 6;
   localparam int ROWS       = 1 << ROW_W;   // Rows per lane bank
   localparam int OFFS_W     = 2;            // Byte offset inside a row
   localparam int BYTE_W     = 8;
   localparam int WORD_W     = LANES * BYTE_W;

   typedef logic [BYTE_W-1:0]     byte_t;
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [MEM_ADDR_W-1:0] byte_addr_t;
   typedef logic [ROW_W-1:0]      row_addr_t;
   typedef logic [LANES-1:0]      lane_mask_t;
   typedef logic [OFFS_W-1:0]     lane_sel_t;
   typedef logic [OFFS_W:0]       byte_cnt_t;   // 0 to 4 bytes

   // Same encoding for store and load sizes
   typedef enum logic [1:0] {
      ACC_NONE = 2'd0,
      ACC_BYTE = 2'd1,
      ACC_HALF = 2'd2,
      ACC_WORD = 2'd3
   } access_size_e;

   typedef struct packed {
      byte_addr_t   addr;
      word_t        st_data;
      access_size_e st_size;
      access_size_e ld_size;
   } mem_req_t;

   // Write request seen by one lane bank
   typedef struct packed {
      logic      en;
      row_addr_t row;
      byte_t     data;
   } lane_wr_t;

   function automatic byte_cnt_t size_bytes(access_size_e size);
      case (size)
         ACC_BYTE: return byte_cnt_t'(1);
         ACC_HALF: return byte_cnt_t'(2);
         ACC_WORD: return byte_cnt_t'(4);
         default:  return byte_cnt_t'(0);
      endcase
   endfunction

   // Lanes below the offset belong to the following row
   function automatic row_addr_t lane_row(byte_addr_t addr, lane_sel_t lane);
      row_addr_t base;
      base = addr[MEM_ADDR_W-1:OFFS_W];
      return (lane < addr[OFFS_W-1:0]) ? row_addr_t'(base + 1'b1) : base;
   endfunction

endpackage

`default_nettype wire

/* store_lane_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module store_lane_steer
   import mem_pkg::*;
(
   input  logic                 i_clk,      // Only used by the check below
   input  mem_req_t             i_req,
   output lane_wr_t [LANES-1:0] o_lane_wr
);

   lane_sel_t                 offs;
   byte_cnt_t                 n_bytes;
   lane_mask_t                wr_mask;
   byte_t     [LANES-1:0]     st_bytes;
   lane_sel_t [LANES-1:0]     rel;        // Store byte index seen by each lane

   assign offs     = i_req.addr[OFFS_W-1:0];
   assign n_bytes  = size_bytes(i_req.st_size);
   assign st_bytes = i_req.st_data;

   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         rel[k]     = lane_sel_t'(k) - offs;           // Wraps mod 4
         wr_mask[k] = (byte_cnt_t'(rel[k]) < n_bytes);
      end
   end

   // Rotate the store word so byte 0 lands on the addressed lane
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         o_lane_wr[k].en   = wr_mask[k];
         o_lane_wr[k].row  = lane_row(i_req.addr, lane_sel_t'(k));
         o_lane_wr[k].data = st_bytes[rel[k]];
      end
   end

   // Enabled lanes must match the store size and stay contiguous
   property p_mask_shape;
      @(posedge i_clk)
         (i_req.st_size == ACC_NONE && wr_mask == 4'b0000) ||
         (i_req.st_size == ACC_BYTE && $onehot(wr_mask)) ||
         (i_req.st_size == ACC_HALF && wr_mask inside {4'b0011, 4'b0110,
                                                       4'b1100, 4'b1001}) ||
         (i_req.st_size == ACC_WORD && wr_mask == 4'b1111);
   endproperty

   a_mask_shape: assert property (p_mask_shape)
      else $error("store_lane_steer: bad lane mask %b for size %s",
                  wr_mask, i_req.st_size.name());

endmodule

`default_nettype wire

/* byte_lane_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_lane_bank
   import mem_pkg::*;
(
   input  logic      i_clk,
   input  lane_wr_t  i_wr,
   input  row_addr_t i_rd_row,
   input  row_addr_t i_dbg_row,
   input  logic      i_dbg_en,
   output byte_t     o_rd_byte,
   output byte_t     o_dbg_byte
);

   byte_t mem [ROWS] = '{default: '0};   // Starts cleared in simulation

   always_ff @(posedge i_clk) begin
      if (i_wr.en) begin
         mem[i_wr.row] <= i_wr.data;
      end
   end

   // Reads see the old byte on a same-cycle write
   always_ff @(posedge i_clk) begin
      if (i_dbg_en) begin
         o_dbg_byte <= mem[i_dbg_row];    // Load byte holds meanwhile
      end else begin
         o_rd_byte <= mem[i_rd_row];
      end
   end

endmodule

`default_nettype wire

/* load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align
   import mem_pkg::*;
(
   input  byte_t [LANES-1:0] i_lane_bytes,   // Lane 0 in bits 7:0
   input  lane_sel_t         i_offset,
   input  access_size_e      i_size,
   output word_t             o_data
);

   logic [2*WORD_W-1:0] doubled;
   logic [4:0]          shamt;
   word_t               rotated;
   word_t               keep;
   byte_cnt_t           n_bytes;

   assign shamt   = {i_offset, 3'b000};        // Offset in bits
   assign doubled = {i_lane_bytes, i_lane_bytes};

   // Addressed byte ends up in bits 7:0, following bytes above it
   always_comb begin
      rotated = word_t'(doubled >> shamt);
   end

   assign n_bytes = size_bytes(i_size);

   // One byte of ones per loaded byte
   always_comb begin
      for (int b = 0; b < LANES; b++) begin
         if (b < n_bytes) begin
            keep[b*BYTE_W +: BYTE_W] = {BYTE_W{1'b1}};
         end else begin
            keep[b*BYTE_W +: BYTE_W] = {BYTE_W{1'b0}};
         end
      end
   end

   assign o_data = rotated & keep;   // ACC_NONE keeps nothing

endmodule

`default_nettype wire

/* data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory
   import mem_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_rst,
   input  mem_req_t  i_req,
   input  logic      i_debug_en,
   input  row_addr_t i_debug_row,
   output word_t     o_data,
   output word_t     o_debug_data
);

   lane_wr_t  [LANES-1:0] lane_wr;
   row_addr_t [LANES-1:0] rd_row;
   byte_t     [LANES-1:0] rd_byte;
   byte_t     [LANES-1:0] dbg_byte;

   access_size_e ld_size_q;
   lane_sel_t    ld_offs_q;
   logic         dbg_seen_q;     // Debug word valid since reset

   store_lane_steer store_lane_steer_inst (
      .i_clk     (i_clk),
      .i_req     (i_req),
      .o_lane_wr (lane_wr)
   );

   // Load rows follow the same wrap rule as the store rows
   always_comb begin
      for (int k = 0; k < LANES; k++) begin
         rd_row[k] = lane_row(i_req.addr, lane_sel_t'(k));
      end
   end

   for (genvar k = 0; k < LANES; k++) begin : g_lane
      byte_lane_bank byte_lane_bank_inst (
         .i_clk      (i_clk),
         .i_wr       (lane_wr[k]),
         .i_rd_row   (rd_row[k]),
         .i_dbg_row  (i_debug_row),   // Same row on every lane
         .i_dbg_en   (i_debug_en),
         .o_rd_byte  (rd_byte[k]),
         .o_dbg_byte (dbg_byte[k])
      );
   end

   // Size and offset ride along with the bank read registers
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ld_size_q  <= ACC_NONE;
         ld_offs_q  <= '0;
         dbg_seen_q <= 1'b0;
      end else if (i_debug_en) begin
         dbg_seen_q <= 1'b1;           // Load side holds its state
      end else begin
         ld_size_q  <= i_req.ld_size;
         ld_offs_q  <= i_req.addr[OFFS_W-1:0];
      end
   end

   // Output only changes when the registers above do
   load_align load_align_inst (
      .i_lane_bytes (rd_byte),
      .i_offset     (ld_offs_q),
      .i_size       (ld_size_q),
      .o_data       (o_data)
   );

   assign o_debug_data = dbg_seen_q ? word_t'(dbg_byte) : '0;   // Row word, lane 3 on top

   // A memory stage never stores and loads in one instruction
   a_no_dual_access: assert property (
      @(posedge i_clk) disable iff (i_rst)
         !(i_req.st_size != ACC_NONE && i_req.ld_size != ACC_NONE))
      else $warning("data_memory: store and load in the same cycle at %h",
                    i_req.addr);

   // Debug reads must leave the load result alone
   a_debug_holds_load: assert property (
      @(posedge i_clk) disable iff (i_rst)
         i_debug_en |=> $stable(o_data))
      else $error("data_memory: o_data changed during a debug cycle");

endmodule

`default_nettype wire

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One directed operation, held on the inputs for a single cycle
typedef struct {
   string        name;
   byte_addr_t   addr;
   word_t        st_data;
   access_size_e st_size;
   access_size_e ld_size;
   logic         dbg_en;
   row_addr_t    dbg_row;
} vec_t;

localparam int N_VECS = 35;

// Name, address, store data, store size, load size, debug enable and debug row
vec_t vecs [N_VECS] = '{
   '{"ld_none_reset",  8'h00, 32'h0000_0000, ACC_NONE, ACC_NONE, 1'b0, 6'd0},
   '{"st_word_a10",    8'h10, 32'h1122_3344, ACC_WORD, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_a10",    8'h10, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_byte_o0",     8'h20, 32'h0000_00aa, ACC_BYTE, ACC_NONE, 1'b0, 6'd0},
   '{"st_byte_o1",     8'h21, 32'h0000_00bb, ACC_BYTE, ACC_NONE, 1'b0, 6'd0},
   '{"st_half_o2",     8'h22, 32'h0000_ddcc, ACC_HALF, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_merge",  8'h20, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"ld_byte_o3",     8'h23, 32'h0000_0000, ACC_NONE, ACC_BYTE, 1'b0, 6'd0},
   '{"st_half_o1",     8'h25, 32'h0000_5566, ACC_HALF, ACC_NONE, 1'b0, 6'd0},
   '{"ld_half_o1",     8'h25, 32'h0000_0000, ACC_NONE, ACC_HALF, 1'b0, 6'd0},
   '{"st_byte_o3",     8'h27, 32'h0000_0077, ACC_BYTE, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_a24",    8'h24, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_half_o0",     8'h2c, 32'h7777_9988, ACC_HALF, ACC_NONE, 1'b0, 6'd0},
   '{"st_byte_o2",     8'h2e, 32'hffff_ff42, ACC_BYTE, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_a2c",    8'h2c, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_half_o3",     8'h33, 32'h0000_beef, ACC_HALF, ACC_NONE, 1'b0, 6'd0},
   '{"ld_half_o3",     8'h33, 32'h0000_0000, ACC_NONE, ACC_HALF, 1'b0, 6'd0},
   '{"st_word_o1",     8'h41, 32'h0102_0304, ACC_WORD, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_o1",     8'h41, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_word_o2",     8'h46, 32'ha1b2_c3d4, ACC_WORD, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_o2",     8'h46, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_word_o3",     8'h4b, 32'h0bad_f00d, ACC_WORD, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_o3",     8'h4b, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_word_a254",   8'hfe, 32'hcafe_f00d, ACC_WORD, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_a254",   8'hfe, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_half_a255",   8'hff, 32'h0000_1234, ACC_HALF, ACC_NONE, 1'b0, 6'd0},
   '{"ld_word_a255",   8'hff, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"st_ld_same",     8'h10, 32'h5566_7788, ACC_WORD, ACC_WORD, 1'b0, 6'd0},
   '{"ld_after_st",    8'h10, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"dbg_row8",       8'h00, 32'h0000_0000, ACC_NONE, ACC_NONE, 1'b1, 6'd8},
   '{"dbg_row0_wrap",  8'h00, 32'h0000_0000, ACC_NONE, ACC_NONE, 1'b1, 6'd0},
   '{"dbg_store",      8'h50, 32'h9abc_def0, ACC_WORD, ACC_NONE, 1'b1, 6'd20},
   '{"dbg_row20",      8'h00, 32'h0000_0000, ACC_NONE, ACC_NONE, 1'b1, 6'd20},
   '{"ld_word_a50",    8'h50, 32'h0000_0000, ACC_NONE, ACC_WORD, 1'b0, 6'd0},
   '{"ld_none_end",    8'h00, 32'h0000_0000, ACC_NONE, ACC_NONE, 1'b0, 6'd0}
};

`endif

/* tb_data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_memory
   import mem_pkg::*;
();

   `include "tb_vectors.svh"

   localparam int N_RANDOM    = 200;
   localparam int RST_TIMEOUT = 10;   // Cycles allowed for known outputs

   logic      clk;
   logic      rst;
   mem_req_t  req;
   logic      debug_en;
   row_addr_t debug_row;
   word_t     data;
   word_t     debug_data;

   byte_t  ref_mem [256];    // Byte-wise reference memory
   word_t  exp_data;         // Expected o_data, holds across debug cycles
   word_t  exp_dbg;
   vec_t   pend;             // Operation whose result shows at the next negedge
   logic   pend_valid;
   logic   report_each;
   int     err_cnt;
   int     pass_cnt;
   int     fail_cnt;
   integer seed = 11127;

   data_memory data_memory_inst (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_req        (req),
      .i_debug_en   (debug_en),
      .i_debug_row  (debug_row),
      .o_data       (data),
      .o_debug_data (debug_data)
   );

   always #4 clk = ~clk;

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   function automatic int byte_count(access_size_e size);
      case (size)
         ACC_BYTE: return 1;
         ACC_HALF: return 2;
         ACC_WORD: return 4;
         default:  return 0;
      endcase
   endfunction

   // Little endian, zero above the loaded bytes
   function automatic word_t model_load(byte_addr_t addr, access_size_e size);
      word_t w;
      w = '0;
      for (int i = 0; i < byte_count(size); i++) begin
         w[8*i +: 8] = ref_mem[byte_addr_t'(addr + i)];
      end
      return w;
   endfunction

   function automatic word_t model_row(row_addr_t row);
      word_t w;
      for (int i = 0; i < 4; i++) begin
         w[8*i +: 8] = ref_mem[int'(row) * 4 + i];
      end
      return w;
   endfunction

   task automatic model_store(input byte_addr_t addr, input word_t wdata,
                              input access_size_e size);
      for (int i = 0; i < byte_count(size); i++) begin
         ref_mem[byte_addr_t'(addr + i)] = wdata[8*i +: 8];   // Wraps at 255
      end
   endtask

   // Reads come first, so a same-cycle store is not seen
   task automatic predict(input vec_t v);
      if (v.dbg_en) begin
         exp_dbg = model_row(v.dbg_row);
      end else begin
         exp_data = model_load(v.addr, v.ld_size);
      end
      model_store(v.addr, v.st_data, v.st_size);
   endtask

   task automatic drive(input vec_t v);
      req.addr    <= v.addr;
      req.st_data <= v.st_data;
      req.st_size <= v.st_size;
      req.ld_size <= v.ld_size;
      debug_en    <= v.dbg_en;
      debug_row   <= v.dbg_row;
   endtask

   task automatic check_pending();
      int errs_before;
      errs_before = err_cnt;
      check_word({pend.name, " o_data"}, exp_data, data);
      check_word({pend.name, " o_debug_data"}, exp_dbg, debug_data);
      if (report_each) begin
         if (err_cnt == errs_before) begin
            $display("pass %s", pend.name);
            pass_cnt++;
         end else begin
            $display("fail %s", pend.name);
            fail_cnt++;
         end
      end
   endtask

   // Drive at the rising edge, check the previous operation at the falling edge
   task automatic step(input vec_t v);
      @(posedge clk);
      drive(v);
      @(negedge clk);
      if (pend_valid) begin
         check_pending();
      end
      predict(v);
      pend       = v;
      pend_valid = 1'b1;
   endtask

   task automatic flush();
      vec_t idle;
      idle = '{"idle", 8'h00, 32'h0, ACC_NONE, ACC_NONE, 1'b0, 6'd0};
      @(posedge clk);
      drive(idle);
      @(negedge clk);
      if (pend_valid) begin
         check_pending();
      end
      predict(idle);
      pend_valid = 1'b0;
   endtask

   task automatic run_table();
      for (int i = 0; i < N_VECS; i++) begin
         step(vecs[i]);
      end
      flush();
   endtask

   // Stores, loads and debug reads, never a store and a load together
   task automatic run_random();
      vec_t        v;
      logic [31:0] rnd;
      int          errs_before;
      report_each = 1'b0;
      errs_before = err_cnt;
      for (int n = 0; n < N_RANDOM; n++) begin
         rnd       = $random(seed);
         v.name    = $sformatf("random_%0d", n);
         v.addr    = byte_addr_t'($random(seed));
         v.st_data = $random(seed);
         v.dbg_row = row_addr_t'($random(seed));
         v.st_size = ACC_NONE;
         v.ld_size = ACC_NONE;
         v.dbg_en  = 1'b0;
         case (rnd[1:0])
            2'd0: v.st_size = access_size_e'(rnd[3:2]);
            2'd1: v.ld_size = access_size_e'(rnd[3:2]);
            2'd2: v.dbg_en  = 1'b1;
            default: begin
               v.dbg_en  = 1'b1;
               v.st_size = access_size_e'(rnd[3:2]);
            end
         endcase
         step(v);
      end
      flush();
      report_each = 1'b1;
      if (err_cnt == errs_before) begin
         $display("pass random_mix (%0d operations)", N_RANDOM);
         pass_cnt++;
      end else begin
         $display("fail random_mix (%0d errors)", err_cnt - errs_before);
         fail_cnt++;
      end
   endtask

   initial begin
      logic ready;
      int   errs_before;
      clk         = 1'b0;
      rst         <= 1'b1;
      req         <= '{addr: '0, st_data: '0, st_size: ACC_NONE, ld_size: ACC_NONE};
      debug_en    <= 1'b0;
      debug_row   <= '0;
      exp_data    = '0;
      exp_dbg     = '0;
      pend_valid  = 1'b0;
      report_each = 1'b1;
      err_cnt     = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      for (int a = 0; a < 256; a++) begin
         ref_mem[a] = '0;
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      ready = 1'b0;
      for (int c = 0; c < RST_TIMEOUT && !ready; c++) begin
         @(negedge clk);
         ready = !$isunknown(data) && !$isunknown(debug_data);
      end

      if (!ready) begin
         $display("timeout: outputs still unknown %0d cycles after reset", RST_TIMEOUT);
         $display("TB FAILED");
         $finish;
      end else begin
         errs_before = err_cnt;
         check_word("reset_outputs o_data", '0, data);
         check_word("reset_outputs o_debug_data", '0, debug_data);
         if (err_cnt == errs_before) begin
            $display("pass reset_outputs");
            pass_cnt++;
         end else begin
            $display("fail reset_outputs");
            fail_cnt++;
         end
         run_table();
         run_random();
         $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
         if (fail_cnt == 0) begin
            $display("TB PASSED");
         end else begin
            $display("TB FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
mem_pkg.sv
store_lane_steer.sv
byte_lane_bank.sv
load_align.sv
data_memory.sv
tb_data_memory.sv
